// File: design/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

    // operand source seen by decode
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXEC,
        FWD_MEM,
        FWD_WB
    } fwdSel_t;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     isBranch;
        logic     branchNe;   // invert the equality test
        logic     useImm;
        aluOp_t   aluOp;
        regAddr_t dst;
    } ctrlSign_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } fetchToDec_t;

    typedef struct packed {
        word_t     pc;
        word_t     opA;
        word_t     opB;
        word_t     imm;
        word_t     branchTarget;
        ctrlSign_t sign;
    } decodeToExec_t;

    typedef struct packed {
        word_t     pc;
        word_t     aluResult;
        word_t     storeData;
        ctrlSign_t sign;
    } execToMem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        regAddr_t dst;
        logic     regWrite;
    } memToWb_t;

    localparam word_t DEFAULT_RESET_PC = 32'hbfc00000;

    localparam logic [5:0] OP_SPECIAL = 6'h00;   // R-type, funct selects
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// File: design/cpuTop.sv
module cpuTop import cpuPkg::*; #(
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic       clk,
    input  logic       rst_i,
    // fetch port
    output word_t      instAddr_o,
    output logic       instEn_o,
    input  word_t      instData_i,
    input  logic       instStall_i,
    // data port
    output logic       dataEn_o,
    output logic       dataWe_o,
    output word_t      dataAddr_o,
    output word_t      dataWdata_o,
    input  word_t      dataRdata_i,
    input  logic       dataStall_i,
    // writeback trace
    output word_t      debugWbPc_o,
    output logic [3:0] debugWbWen_o,
    output regAddr_t   debugWbWnum_o,
    output word_t      debugWbWdata_o
);

    fetchToDec_t   fetchF;
    fetchToDec_t   fetchD;
    decodeToExec_t decD;
    decodeToExec_t decE;
    execToMem_t    execE;
    execToMem_t    execM;
    memToWb_t      memM;
    memToWb_t      memW;
    regAddr_t      rsD;
    regAddr_t      rtD;
    word_t         rd1D;
    word_t         rd2D;
    logic          jumpTakenD;
    word_t         jumpTargetD;
    logic          branchTakenE;
    word_t         branchTargetE;
    word_t         execResultE;
    word_t         memResultM;
    logic          wbWrite;

    pipeCtrlIf ctrl ();

    // a frozen M/W entry retires once
    assign wbWrite = memW.regWrite & ~ctrl.freeze;

    fetchUnit #(.RESET_PC(RESET_PC)) fetch (
        .clk(clk), .rst_i(rst_i), .ctrl(ctrl),
        .branchTaken_i(branchTakenE), .branchTarget_i(branchTargetE),
        .jumpTaken_i(jumpTakenD), .jumpTarget_i(jumpTargetD),
        .instData_i(instData_i), .instAddr_o(instAddr_o), .instEn_o(instEn_o),
        .fetchOut_o(fetchF)
    );

    stageReg #(.payload_t(fetchToDec_t)) fdReg (
        .clk(clk), .rst_i(rst_i), .stall_i(ctrl.freeze | ctrl.stallFront),
        .flush_i(ctrl.flushDec), .d_i(fetchF), .q_o(fetchD)
    );

    decodeStage decode (
        .ctrl(ctrl), .fetchIn_i(fetchD), .rd1_i(rd1D), .rd2_i(rd2D),
        .execResult_i(execResultE), .memResult_i(memResultM), .wbResult_i(memW.result),
        .rs_o(rsD), .rt_o(rtD), .jumpTaken_o(jumpTakenD), .jumpTarget_o(jumpTargetD),
        .decOut_o(decD)
    );

    regFile regs (
        .clk(clk), .rst_i(rst_i), .raddr1_i(rsD), .raddr2_i(rtD),
        .we_i(wbWrite), .waddr_i(memW.dst), .wdata_i(memW.result),
        .rdata1_o(rd1D), .rdata2_o(rd2D)
    );

    hazardUnit hazard (
        .rs_i(rsD), .rt_i(rtD),
        .execDst_i(decE.sign.dst), .execRegWrite_i(decE.sign.regWrite),
        .execMemRead_i(decE.sign.memRead),
        .memDst_i(execM.sign.dst), .memRegWrite_i(execM.sign.regWrite),
        .wbDst_i(memW.dst), .wbRegWrite_i(memW.regWrite),
        .branchTaken_i(branchTakenE), .instStall_i(instStall_i), .dataStall_i(dataStall_i),
        .ctrl(ctrl)
    );

    stageReg #(.payload_t(decodeToExec_t)) deReg (
        .clk(clk), .rst_i(rst_i), .stall_i(ctrl.freeze),
        .flush_i(ctrl.flushExec), .d_i(decD), .q_o(decE)
    );

    executeUnit execute (
        .execIn_i(decE), .branchTaken_o(branchTakenE), .branchTarget_o(branchTargetE),
        .execOut_o(execE), .execResult_o(execResultE)
    );

    stageReg #(.payload_t(execToMem_t)) emReg (
        .clk(clk), .rst_i(rst_i), .stall_i(ctrl.freeze),
        .flush_i(1'b0), .d_i(execE), .q_o(execM)
    );

    memStage mem (
        .memIn_i(execM), .dataRdata_i(dataRdata_i),
        .dataEn_o(dataEn_o), .dataWe_o(dataWe_o),
        .dataAddr_o(dataAddr_o), .dataWdata_o(dataWdata_o),
        .memOut_o(memM), .memResult_o(memResultM)
    );

    stageReg #(.payload_t(memToWb_t)) mwReg (
        .clk(clk), .rst_i(rst_i), .stall_i(ctrl.freeze),
        .flush_i(1'b0), .d_i(memM), .q_o(memW)
    );

    assign debugWbPc_o    = memW.pc;
    assign debugWbWen_o   = {4{wbWrite}};
    assign debugWbWnum_o  = memW.dst;
    assign debugWbWdata_o = memW.result;

endmodule

// File: design/decodeStage.sv
module decodeStage import cpuPkg::*; (
    pipeCtrlIf.front      ctrl,
    input  fetchToDec_t   fetchIn_i,
    input  word_t         rd1_i,
    input  word_t         rd2_i,
    input  word_t         execResult_i,
    input  word_t         memResult_i,
    input  word_t         wbResult_i,
    output regAddr_t      rs_o,
    output regAddr_t      rt_o,
    output logic          jumpTaken_o,
    output word_t         jumpTarget_o,
    output decodeToExec_t decOut_o
);

    word_t     instr;
    word_t     slotPc;
    word_t     imm;
    ctrlSign_t sign;
    logic      known;
    logic      usesRs;
    logic      usesRt;
    logic      signExt;
    logic      isJump;
    logic      rdDst;

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal);
        case (sel)
            FWD_EXEC: return execResult_i;
            FWD_MEM:  return memResult_i;
            FWD_WB:   return wbResult_i;
            default:  return regVal;
        endcase
    endfunction

    assign instr  = fetchIn_i.instr;
    assign slotPc = fetchIn_i.pc + 32'd4;

    always_comb begin
        sign    = '0;
        known   = 1'b1;
        usesRs  = 1'b1;
        usesRt  = 1'b0;
        signExt = 1'b1;
        isJump  = 1'b0;
        rdDst   = 1'b0;
        case (instr[31:26])
            OP_SPECIAL: begin
                sign.regWrite = 1'b1;
                usesRt        = 1'b1;
                rdDst         = 1'b1;
                case (instr[5:0])
                    FN_ADDU: sign.aluOp = ALU_ADD;
                    FN_SUBU: sign.aluOp = ALU_SUB;
                    FN_AND:  sign.aluOp = ALU_AND;
                    FN_OR:   sign.aluOp = ALU_OR;
                    FN_SLT:  sign.aluOp = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: {sign.regWrite, sign.useImm} = 2'b11;
            OP_ORI: begin
                {sign.regWrite, sign.useImm} = 2'b11;
                sign.aluOp = ALU_OR;
                signExt    = 1'b0;
            end
            OP_LUI: begin
                {sign.regWrite, sign.useImm} = 2'b11;
                sign.aluOp = ALU_LUI;
                signExt    = 1'b0;
                usesRs     = 1'b0;
            end
            OP_LW: {sign.regWrite, sign.memRead, sign.useImm} = 3'b111;
            OP_SW: begin
                {sign.memWrite, sign.useImm} = 2'b11;
                usesRt = 1'b1;
            end
            OP_BEQ: begin
                sign.isBranch = 1'b1;
                usesRt        = 1'b1;
            end
            OP_BNE: begin
                {sign.isBranch, sign.branchNe} = 2'b11;
                usesRt = 1'b1;
            end
            OP_J: begin
                isJump = 1'b1;
                usesRs = 1'b0;
            end
            default: known = 1'b0;
        endcase
        sign.dst      = rdDst ? instr[15:11] : instr[20:16];
        sign.regWrite = sign.regWrite && (sign.dst != '0);   // writes to r0 vanish
        if (!sign.regWrite) sign.dst = '0;
        if (!known || !fetchIn_i.valid) begin
            sign   = '0;
            usesRs = 1'b0;
            usesRt = 1'b0;
            isJump = 1'b0;
        end
    end

    assign imm  = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
    assign rs_o = usesRs ? instr[25:21] : '0;   // unused fields never raise hazards
    assign rt_o = usesRt ? instr[20:16] : '0;

    assign jumpTaken_o  = isJump;
    assign jumpTarget_o = {slotPc[31:28], instr[25:0], 2'b00};

    assign decOut_o = '{
        pc:           fetchIn_i.pc,
        opA:          fwdMux(ctrl.fwdA, rd1_i),
        opB:          fwdMux(ctrl.fwdB, rd2_i),
        imm:          imm,
        branchTarget: slotPc + {imm[29:0], 2'b00},
        sign:         sign
    };

endmodule

// File: design/executeUnit.sv
module executeUnit import cpuPkg::*; (
    input  decodeToExec_t execIn_i,
    output logic          branchTaken_o,
    output word_t         branchTarget_o,
    output execToMem_t    execOut_o,
    output word_t         execResult_o
);

    word_t aluB;
    word_t aluOut;
    logic  operandsEq;

    assign aluB = execIn_i.sign.useImm ? execIn_i.imm : execIn_i.opB;

    always_comb begin
        case (execIn_i.sign.aluOp)
            ALU_ADD: aluOut = execIn_i.opA + aluB;
            ALU_SUB: aluOut = execIn_i.opA - aluB;
            ALU_AND: aluOut = execIn_i.opA & aluB;
            ALU_OR:  aluOut = execIn_i.opA | aluB;
            ALU_SLT: aluOut = {31'b0, $signed(execIn_i.opA) < $signed(aluB)};
            ALU_LUI: aluOut = {aluB[15:0], 16'b0};
            default: aluOut = '0;
        endcase
    end

    // beq and bne compare the two register operands, never the immediate
    assign operandsEq     = execIn_i.opA == execIn_i.opB;
    assign branchTaken_o  = execIn_i.sign.isBranch & (operandsEq ^ execIn_i.sign.branchNe);
    assign branchTarget_o = execIn_i.branchTarget;

    assign execOut_o = '{
        pc:        execIn_i.pc,
        aluResult: aluOut,
        storeData: execIn_i.opB,   // rt value for sw
        sign:      execIn_i.sign
    };

    assign execResult_o = aluOut;   // forward to decode

endmodule

// File: design/fetchUnit.sv
module fetchUnit import cpuPkg::*; #(
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic        clk,
    input  logic        rst_i,
    pipeCtrlIf.front    ctrl,
    input  logic        branchTaken_i,
    input  word_t       branchTarget_i,
    input  logic        jumpTaken_i,
    input  word_t       jumpTarget_i,
    input  word_t       instData_i,
    output word_t       instAddr_o,
    output logic        instEn_o,
    output fetchToDec_t fetchOut_o
);

    word_t pc;
    word_t pcNext;
    logic  fetchEn;   // first request goes out the cycle after reset

    always_comb begin
        if (!fetchEn || ctrl.freeze || ctrl.stallFront) begin
            pcNext = pc;
        end else if (branchTaken_i) begin
            pcNext = branchTarget_i;   // branch in execute beats jump in decode
        end else if (jumpTaken_i) begin
            pcNext = jumpTarget_i;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc      <= RESET_PC;
            fetchEn <= 1'b0;
        end else begin
            pc      <= pcNext;
            fetchEn <= 1'b1;
        end
    end

    assign instAddr_o = pc;
    assign instEn_o   = fetchEn;
    // wrong-path word behind a taken branch
    assign fetchOut_o = '{pc: pc, instr: instData_i, valid: fetchEn & ~ctrl.flushDec};

    pcAligned: assert property (@(posedge clk) disable iff (rst_i) pc[1:0] == 2'b00)
        else $error("fetchUnit: pc %h not word aligned", pc);

endmodule

// File: design/hazardUnit.sv
module hazardUnit import cpuPkg::*; (
    input  regAddr_t   rs_i,
    input  regAddr_t   rt_i,
    input  regAddr_t   execDst_i,
    input  logic       execRegWrite_i,
    input  logic       execMemRead_i,
    input  regAddr_t   memDst_i,
    input  logic       memRegWrite_i,
    input  regAddr_t   wbDst_i,
    input  logic       wbRegWrite_i,
    input  logic       branchTaken_i,
    input  logic       instStall_i,
    input  logic       dataStall_i,
    pipeCtrlIf.hazard  ctrl
);

    logic loadUse;

    // youngest producer wins
    function automatic fwdSel_t pickSource(input regAddr_t src);
        if (src == '0) return FWD_REG;
        if (execRegWrite_i && execDst_i == src) return FWD_EXEC;
        if (memRegWrite_i && memDst_i == src) return FWD_MEM;
        if (wbRegWrite_i && wbDst_i == src) return FWD_WB;
        return FWD_REG;
    endfunction

    // load data only exists one stage later
    assign loadUse = execMemRead_i && execRegWrite_i &&
                     (execDst_i == rs_i || execDst_i == rt_i);

    assign ctrl.freeze     = instStall_i | dataStall_i;
    assign ctrl.stallFront = loadUse;
    assign ctrl.flushExec  = loadUse;
    assign ctrl.flushDec   = branchTaken_i;   // drop the fetch behind the delay slot
    assign ctrl.fwdA       = pickSource(rs_i);
    assign ctrl.fwdB       = pickSource(rt_i);

    // a load and a branch never share the execute stage
    always_comb begin
        assert final (!(ctrl.flushDec && ctrl.stallFront) || ctrl.freeze)
            else $error("hazardUnit: flush and front stall together");
    end

endmodule

// File: design/memStage.sv
module memStage import cpuPkg::*; (
    input  execToMem_t memIn_i,
    input  word_t      dataRdata_i,
    output logic       dataEn_o,
    output logic       dataWe_o,
    output word_t      dataAddr_o,
    output word_t      dataWdata_o,
    output memToWb_t   memOut_o,
    output word_t      memResult_o
);

    assign dataEn_o    = memIn_i.sign.memRead | memIn_i.sign.memWrite;
    assign dataWe_o    = memIn_i.sign.memWrite;
    assign dataAddr_o  = memIn_i.aluResult;
    assign dataWdata_o = memIn_i.storeData;

    // load data is valid only while dataStall_i is low
    assign memResult_o = memIn_i.sign.memRead ? dataRdata_i : memIn_i.aluResult;

    assign memOut_o = '{
        pc:       memIn_i.pc,
        result:   memResult_o,
        dst:      memIn_i.sign.dst,
        regWrite: memIn_i.sign.regWrite
    };

    // base plus offset from decode and execute must land on a word
    always_comb begin
        assert final (!dataEn_o || dataAddr_o[1:0] == 2'b00)
            else $error("memStage: unaligned data address %h", dataAddr_o);
    end

endmodule

// File: design/pipeCtrlIf.sv
interface pipeCtrlIf import cpuPkg::*; ();

    logic    freeze;       // a memory port is stalled
    logic    flushDec;     // F/D takes a bubble
    logic    flushExec;    // D/E takes a bubble
    logic    stallFront;   // pc and F/D hold
    fwdSel_t fwdA;
    fwdSel_t fwdB;

    modport hazard (
        output freeze, flushDec, flushExec, stallFront, fwdA, fwdB
    );

    modport front (
        input freeze, flushDec, stallFront, fwdA, fwdB
    );

    // stage register controls
    modport pipe (
        input freeze, flushDec, flushExec, stallFront
    );

endinterface

// File: design/regFile.sv
module regFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  regAddr_t raddr1_i,
    input  regAddr_t raddr2_i,
    input  logic     we_i,
    input  regAddr_t waddr_i,
    input  word_t    wdata_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;   // r0 stays zero
        end
    end

    // same-cycle writes reach decode through the wb forward path
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// File: design/stageReg.sv
module stageReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // stall wins over flush, so a held stage keeps its instruction
    always_ff @(posedge clk) begin
        if (rst_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= flush_i ? '0 : d_i;   // zero payload is a bubble
        end
    end

    bubbleAfterClear: assert property (
        @(posedge clk) (rst_i || (flush_i && !stall_i)) |=> (q_o == '0)
    ) else $error("stageReg: payload not cleared after reset or flush");

endmodule

// File: project.f
design/cpuPkg.sv
design/pipeCtrlIf.sv
design/stageReg.sv
design/fetchUnit.sv
design/decodeStage.sv
design/regFile.sv
design/hazardUnit.sv
design/executeUnit.sv
design/memStage.sv
design/cpuTop.sv
tests/tbCpu.sv

// File: run.sh
#!/bin/sh
# builds and runs the cpuTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tbCpu \
    -Mdir build -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./build/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// File: tests/tbCpu.sv
module tbCpu import cpuPkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC   = 32'hbfc00000;
    localparam int    PROG_WORDS = 256;
    localparam int    TIMEOUT    = 5000;

    logic       clk = 1'b0;
    logic       rst_i;
    word_t      instAddr_o;
    logic       instEn_o;
    word_t      instData_i;
    logic       instStall_i;
    logic       dataEn_o;
    logic       dataWe_o;
    word_t      dataAddr_o;
    word_t      dataWdata_o;
    word_t      dataRdata_i;
    logic       dataStall_i;
    word_t      debugWbPc_o;
    logic [3:0] debugWbWen_o;
    regAddr_t   debugWbWnum_o;
    word_t      debugWbWdata_o;

    word_t    prog [PROG_WORDS];
    word_t    dmem [64];
    word_t    modelMem [64];
    int       progLen;
    word_t    loopPc;
    word_t    instIdx;
    word_t    expPc [$];
    regAddr_t expReg [$];
    word_t    expVal [$];
    word_t    rngState = 32'had156b55;
    logic     stallEn = 1'b0;
    logic     checkReset = 1'b0;
    logic     timedOut = 1'b0;
    int       errors = 0;
    int       passed = 0;
    int       failed = 0;

    cpuTop #(.RESET_PC(RESET_PC)) i_dut (.*);

    always #4 clk = ~clk;

    // memory models answer combinationally
    assign instIdx     = (instAddr_o - RESET_PC) >> 2;
    assign instData_i  = (instIdx < PROG_WORDS) ? prog[instIdx[7:0]] : 32'h0;
    assign dataRdata_i = dmem[dataAddr_o[7:2]];

    function automatic word_t fillWord(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c6ef372;
    endfunction

    function word_t nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic word_t rType(input logic [5:0] fn, input regAddr_t rs, rt, rd);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regAddr_t rs, rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function regAddr_t pickDst();
        return regAddr_t'(nextRandom() % 7 + 1);   // r1..r7, keeps reuse high
    endfunction

    function regAddr_t pickSrc();
        return regAddr_t'(nextRandom() % 8);
    endfunction

    always @(posedge clk) begin
        #1;
        if (stallEn) begin
            word_t r;
            r = nextRandom();
            instStall_i = (r[1:0] == 2'b00);
            dataStall_i = (r[3:2] == 2'b00);
        end else begin
            instStall_i = 1'b0;
            dataStall_i = 1'b0;
        end
    end

    // store is taken in a cycle without data stall
    always @(negedge clk) begin
        if (dataEn_o && dataWe_o && !dataStall_i) dmem[dataAddr_o[7:2]] <= dataWdata_o;
    end

    always @(negedge clk) begin
        if (checkReset) begin
            assert (instAddr_o == RESET_PC && debugWbWen_o == 4'h0 &&
                    !dataEn_o && !dataWe_o && (!rst_i || !instEn_o))
            else begin
                $display("mismatch at %0t: reset state pc %h wen %h en %b we %b fetch en %b",
                         $time, instAddr_o, debugWbWen_o, dataEn_o, dataWe_o, instEn_o);
                errors++;
            end
        end
        if (!rst_i && debugWbWen_o != 4'h0) begin
            assert (expPc.size() != 0)
            else begin
                $display("register write from pc %h while no write was predicted",
                         debugWbPc_o);
                errors++;
            end
            if (expPc.size() != 0) begin
                assert (debugWbWen_o == 4'hf && debugWbPc_o == expPc[0] &&
                        debugWbWnum_o == expReg[0] && debugWbWdata_o == expVal[0])
                else begin
                    $display("mismatch at %0t: pc %h r%0d=%h, expected pc %h r%0d=%h", $time,
                             debugWbPc_o, debugWbWnum_o, debugWbWdata_o,
                             expPc[0], expReg[0], expVal[0]);
                    errors++;
                end
                void'(expPc.pop_front());
                void'(expReg.pop_front());
                void'(expVal.pop_front());
            end
        end
    end

    task automatic emit(input word_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic emitAlu();
        word_t    r;
        regAddr_t d;
        r = nextRandom();
        d = pickDst();
        case (r[2:0])
            3'd0: emit(rType(6'h21, pickSrc(), pickSrc(), d));   // addu
            3'd1: emit(rType(6'h23, pickSrc(), pickSrc(), d));   // subu
            3'd2: emit(rType(6'h24, pickSrc(), pickSrc(), d));
            3'd3: emit(rType(6'h25, pickSrc(), pickSrc(), d));
            3'd4: emit(rType(6'h2a, pickSrc(), pickSrc(), d));   // slt
            3'd5: emit(iType(6'h09, pickSrc(), d, r[31:16]));    // addiu
            3'd6: emit(iType(6'h0d, pickSrc(), d, r[31:16]));    // ori
            default: emit(iType(6'h0f, 5'd0, d, r[31:16]));      // lui
        endcase
    endtask

    // kind bits: 1 arithmetic, 2 memory, 4 control flow
    task automatic genProgram(input int kind);
        word_t    r;
        int       off;
        int       brIdx;
        regAddr_t d;
        progLen = 0;
        for (int i = 0; i < PROG_WORDS; i++) prog[i] = 32'h0;
        for (int i = 1; i < 8; i++) begin
            r = nextRandom();
            emit(iType(6'h0f, 5'd0, regAddr_t'(i), r[15:0]));
            emit(iType(6'h0d, regAddr_t'(i), regAddr_t'(i), r[31:16]));
        end
        if (kind[0]) repeat (40) emitAlu();
        if (kind[1]) begin
            repeat (12) begin
                r = nextRandom();
                d = pickDst();
                emit(iType(6'h2b, 5'd0, pickSrc(), {10'd0, r[3:0], 2'b00}));   // sw
                emit(iType(6'h23, 5'd0, d, {10'd0, r[3:0], 2'b00}));           // lw
                emit(rType(6'h21, d, pickSrc(), pickDst()));   // uses the load at once
                if (r[8]) emit(iType(6'h23, 5'd0, pickDst(), {10'd0, r[7:4], 2'b00}));
            end
        end
        if (kind[2]) begin
            repeat (12) begin
                r = nextRandom();
                off = int'(r % 3) + 1;
                brIdx = progLen;
                case (r[9:8])
                    2'd0: emit(iType(6'h04, pickSrc(), pickSrc(), 16'(off)));
                    2'd1: emit(iType(6'h05, pickSrc(), pickSrc(), 16'(off)));
                    2'd2: begin
                        d = pickSrc();
                        emit(iType(6'h04, d, d, 16'(off)));   // always taken
                    end
                    default: begin
                        r = RESET_PC + word_t'((brIdx + 1 + off) * 4);
                        emit({6'h02, r[27:2]});
                    end
                endcase
                emitAlu();   // delay slot
                repeat (off - 1) emitAlu();
                emitAlu();
            end
        end
        loopPc = RESET_PC + word_t'(progLen * 4);
        emit({6'h02, loopPc[27:2]});
        emit(32'h0);
    endtask

    // in-order instruction-set model with delay slots
    task automatic runModel();
        word_t    r [32];
        word_t    pc;
        word_t    npc;
        word_t    nn;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    sext;
        word_t    addr;
        regAddr_t dst;
        logic     wr;
        int       steps;
        for (int i = 0; i < 32; i++) r[i] = 32'h0;
        pc = RESET_PC;
        npc = pc + 32'd4;
        steps = 0;
        while (pc != loopPc && steps < 2000) begin
            ins  = prog[8'((pc - RESET_PC) >> 2)];
            a    = r[ins[25:21]];
            b    = r[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            addr = a + sext;
            nn   = npc + 32'd4;
            dst  = ins[20:16];
            wr   = 1'b1;
            res  = 32'h0;
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h2a: res = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = addr;
                6'h0d: res = a | {16'h0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0};
                6'h23: res = modelMem[addr[7:2]];
                6'h2b: begin
                    modelMem[addr[7:2]] = b;
                    wr = 1'b0;
                end
                6'h04: begin
                    if (a == b) nn = npc + (sext << 2);
                    wr = 1'b0;
                end
                6'h05: begin
                    if (a != b) nn = npc + (sext << 2);
                    wr = 1'b0;
                end
                6'h02: begin
                    nn = {npc[31:28], ins[25:0], 2'b00};
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                r[dst] = res;
                expPc.push_back(pc);
                expReg.push_back(dst);
                expVal.push_back(res);
            end
            pc = npc;
            npc = nn;
            steps++;
        end
        assert (pc == loopPc)
        else begin
            $display("reference model never reached the final loop");
            errors++;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 rst_i = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst_i = 1'b0;
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout while waiting for %s", what);
        timedOut = 1'b1;
        errors++;
    endtask

    task automatic finishTest(input int num, input string name, input int errBefore);
        if (errors == errBefore) passed++;
        else failed++;
        $display("test %0d %s: %0d errors", num, name, errors - errBefore);
    endtask

    task automatic runTest(input int num, input string name, input int kind, input logic stalls);
        int errBefore;
        int cycles;
        errBefore = errors;
        stallEn = 1'b0;
        genProgram(kind);
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(word_t'(i * 4));
            modelMem[i] = fillWord(word_t'(i * 4));
        end
        expPc.delete();
        expReg.delete();
        expVal.delete();
        runModel();
        applyReset();
        stallEn = stalls;
        cycles = 0;
        while (expPc.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (expPc.size() != 0) begin
            reportTimeout("the predicted register writes");
        end else begin
            cycles = 0;
            while (instAddr_o != loopPc && cycles < TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (instAddr_o != loopPc) begin
                reportTimeout("the final self-loop");
            end else begin
                repeat (20) @(posedge clk);   // stray writes show up here
            end
        end
        finishTest(num, name, errBefore);
    endtask

    initial begin
        int errBefore;
        rst_i = 1'b1;
        instStall_i = 1'b0;
        dataStall_i = 1'b0;
        errBefore = errors;
        checkReset = 1'b1;
        applyReset();
        @(posedge clk);   // one check in the cycle after reset
        checkReset = 1'b0;
        finishTest(1, "reset state", errBefore);
        runTest(2, "dependent arithmetic", 1, 1'b0);
        if (!timedOut) runTest(3, "memory", 2, 1'b0);
        if (!timedOut) runTest(4, "control flow", 4, 1'b0);
        if (!timedOut) runTest(5, "back-pressure", 7, 1'b1);
        $display("tests passed %0d, failed %0d, checks failed %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
